/* src/term_pkg.sv */
// shared widths, blank character and control codes for the text terminal RTL and testbench
package term_pkg;

    localparam int ROW_W  = 5;             // row index
    localparam int COL_W  = 6;             // column index
    localparam int ADDR_W = ROW_W + COL_W; // {row, col}, row in the upper bits
    localparam int CHAR_W = 8;

    localparam logic [CHAR_W-1:0] BLANK      = 8'h20; // fill for clear and scroll
    localparam logic [CHAR_W-1:0] POS_OFFSET = 8'h20; // keeps DC4 arguments printable

    localparam int unsigned TAB_STEP = 8;

    // control codes handled by the interpreter
    localparam logic [CHAR_W-1:0] C_NUL = 8'h00;
    localparam logic [CHAR_W-1:0] C_BEL = 8'h07;
    localparam logic [CHAR_W-1:0] C_BS  = 8'h08;
    localparam logic [CHAR_W-1:0] C_HT  = 8'h09;
    localparam logic [CHAR_W-1:0] C_LF  = 8'h0A;
    localparam logic [CHAR_W-1:0] C_FF  = 8'h0C;
    localparam logic [CHAR_W-1:0] C_CR  = 8'h0D;
    localparam logic [CHAR_W-1:0] C_DC4 = 8'h14; // next two bytes are row, col
    localparam logic [CHAR_W-1:0] C_DEL = 8'h7F;

endpackage

/* src/text_vram.sv */
// character memory; read/write port for the controller, read-only port for the display scanner
`timescale 1ns/1ps

module text_vram (
    input  logic                        i_clk,
    // controller side
    input  logic [term_pkg::ADDR_W-1:0] i_addr,
    input  logic [term_pkg::CHAR_W-1:0] i_wdata,
    input  logic                        i_we,
    output logic [term_pkg::CHAR_W-1:0] o_rdata,
    // display side
    input  logic [term_pkg::ADDR_W-1:0] i_disp_addr,
    output logic [term_pkg::CHAR_W-1:0] o_disp_data
);

    localparam int DEPTH = 2 ** term_pkg::ADDR_W;  // 2048 cells

    logic [term_pkg::CHAR_W-1:0] mem [0:DEPTH-1];
    logic [term_pkg::CHAR_W-1:0] rdata_q;
    logic [term_pkg::CHAR_W-1:0] disp_q;

    // write and read on the same edge; the read sees the old byte
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
        rdata_q <= mem[i_addr];
    end

    always_ff @(posedge i_clk) begin
        disp_q <= mem[i_disp_addr];  // one cycle latency for the scanner
    end

    assign o_rdata     = rdata_q;
    assign o_disp_data = disp_q;

endmodule

/* src/clear_engine.sv */
// clear sequencer; writes the blank character to every visible cell, one per clock
`timescale 1ns/1ps

module clear_engine #(
    parameter int unsigned LAST_ROW = 16,
    parameter int unsigned LAST_COL = 59
) (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_start,
    output logic                        o_busy,
    output logic [term_pkg::ADDR_W-1:0] o_vram_addr,
    output logic [term_pkg::CHAR_W-1:0] o_vram_wdata,
    output logic                        o_vram_we
);

    localparam logic [term_pkg::ROW_W-1:0] ROW_LAST = LAST_ROW[term_pkg::ROW_W-1:0];
    localparam logic [term_pkg::COL_W-1:0] COL_LAST = LAST_COL[term_pkg::COL_W-1:0];

    logic                       busy_q;
    logic [term_pkg::ROW_W-1:0] row_q;
    logic [term_pkg::COL_W-1:0] col_q;

    assign o_busy       = busy_q;
    assign o_vram_we    = busy_q;           // one cell per cycle while running
    assign o_vram_addr  = {row_q, col_q};
    assign o_vram_wdata = term_pkg::BLANK;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            busy_q <= 1'b0;
            row_q  <= '0;
            col_q  <= '0;
        end else if (!busy_q) begin
            if (i_start) begin
                busy_q <= 1'b1;
                row_q  <= '0;
                col_q  <= '0;
            end
        end else if (col_q == COL_LAST) begin
            col_q <= '0;
            if (row_q == ROW_LAST) begin
                busy_q <= 1'b0;  // last cell written
            end else begin
                row_q <= row_q + 1'b1;
            end
        end else begin
            col_q <= col_q + 1'b1;
        end
    end

endmodule

/* src/scroll_engine.sv */
// scroll sequencer; copies rows 1..last up one row, then blanks the bottom row
`timescale 1ns/1ps

module scroll_engine #(
    parameter int unsigned LAST_ROW = 16,
    parameter int unsigned LAST_COL = 59
) (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_start,
    output logic                        o_busy,
    output logic [term_pkg::ADDR_W-1:0] o_vram_addr,
    output logic [term_pkg::CHAR_W-1:0] o_vram_wdata,
    output logic                        o_vram_we,
    input  logic [term_pkg::CHAR_W-1:0] i_vram_rdata
);

    localparam logic [term_pkg::ROW_W-1:0] ROW_LAST = LAST_ROW[term_pkg::ROW_W-1:0];
    localparam logic [term_pkg::COL_W-1:0] COL_LAST = LAST_COL[term_pkg::COL_W-1:0];

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_READ,   // fetch source cell
        PH_WRITE,  // store it one row up
        PH_FILL    // blank the bottom row
    } phase_t;

    phase_t                     phase_q;
    logic [term_pkg::ROW_W-1:0] row_q;  // source row of the copy
    logic [term_pkg::COL_W-1:0] col_q;

    assign o_busy       = (phase_q != PH_IDLE);
    assign o_vram_we    = (phase_q == PH_WRITE) || (phase_q == PH_FILL);
    assign o_vram_wdata = (phase_q == PH_FILL) ? term_pkg::BLANK : i_vram_rdata;

    always_comb begin
        case (phase_q)
            PH_WRITE: o_vram_addr = {row_q - 1'b1, col_q};
            PH_FILL:  o_vram_addr = {ROW_LAST, col_q};
            default:  o_vram_addr = {row_q, col_q};
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            phase_q <= PH_IDLE;
            row_q   <= '0;
            col_q   <= '0;
        end else begin
            case (phase_q)
                PH_IDLE: begin
                    if (i_start) begin
                        row_q   <= 1;
                        col_q   <= '0;
                        phase_q <= (ROW_LAST == '0) ? PH_FILL : PH_READ;  // one-row screen
                    end
                end
                PH_READ: phase_q <= PH_WRITE;
                PH_WRITE: begin
                    phase_q <= PH_READ;
                    if (col_q == COL_LAST) begin
                        col_q <= '0;
                        if (row_q == ROW_LAST) begin
                            phase_q <= PH_FILL;
                        end else begin
                            row_q <= row_q + 1'b1;
                        end
                    end else begin
                        col_q <= col_q + 1'b1;
                    end
                end
                PH_FILL: begin
                    if (col_q == COL_LAST) begin
                        phase_q <= PH_IDLE;  // busy drops after this write
                    end else begin
                        col_q <= col_q + 1'b1;
                    end
                end
                default: phase_q <= PH_IDLE;
            endcase
        end
    end

endmodule

/* src/term_control.sv */
// byte interpreter of the text terminal; moves the cursor, writes characters, runs scroll/clear
`timescale 1ns/1ps

module term_control #(
    parameter int unsigned LAST_ROW = 16,
    parameter int unsigned LAST_COL = 59
) (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic [term_pkg::CHAR_W-1:0] i_char,
    input  logic                        i_valid,
    output logic                        o_ready,
    output logic [term_pkg::ROW_W-1:0]  o_cursor_row,
    output logic [term_pkg::COL_W-1:0]  o_cursor_col,
    output logic [term_pkg::ADDR_W-1:0] o_vram_addr,
    output logic [term_pkg::CHAR_W-1:0] o_vram_wdata,
    output logic                        o_vram_we,
    input  logic [term_pkg::CHAR_W-1:0] i_vram_rdata
);

    localparam logic [term_pkg::ROW_W-1:0] ROW_LAST = LAST_ROW[term_pkg::ROW_W-1:0];
    localparam logic [term_pkg::COL_W-1:0] COL_LAST = LAST_COL[term_pkg::COL_W-1:0];
    localparam logic [term_pkg::COL_W:0]   TAB_INC  = term_pkg::TAB_STEP[term_pkg::COL_W:0];
    localparam logic [term_pkg::COL_W:0]   TAB_MASK = TAB_INC - 1'b1;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_NEW,       // byte held, decode it
        ST_WRITING,   // write strobe to VRAM
        ST_SCROLLING,
        ST_CLEARING,
        ST_WAIT_ROW,  // DC4 seen
        ST_WAIT_COL
    } state_t;

    state_t                        state_q;
    logic [term_pkg::CHAR_W-1:0]   char_q;
    logic [term_pkg::ROW_W-1:0]    row_q;
    logic [term_pkg::COL_W-1:0]    col_q;
    logic                          scroll_start_q;
    logic                          clear_start_q;

    logic [term_pkg::CHAR_W-1:0]   pos_val;
    logic [term_pkg::COL_W:0]      tab_sum;
    logic [term_pkg::COL_W:0]      tab_next;
    logic [term_pkg::COL_W-1:0]    tab_col;

    logic [term_pkg::ADDR_W-1:0]   scr_addr;
    logic [term_pkg::CHAR_W-1:0]   scr_wdata;
    logic                          scr_we;
    logic                          scr_busy;
    logic [term_pkg::ADDR_W-1:0]   clr_addr;
    logic [term_pkg::CHAR_W-1:0]   clr_wdata;
    logic                          clr_we;
    logic                          clr_busy;

    assign o_ready      = (state_q == ST_IDLE) || (state_q == ST_WAIT_ROW) ||
                          (state_q == ST_WAIT_COL);
    assign o_cursor_row = row_q;
    assign o_cursor_col = col_q;

    assign pos_val  = i_char - term_pkg::POS_OFFSET;  // DC4 argument
    assign tab_sum  = {1'b0, col_q} + TAB_INC;
    assign tab_next = tab_sum & ~TAB_MASK;            // round down to tab stop
    assign tab_col  = (tab_next > {1'b0, COL_LAST}) ? COL_LAST : tab_next[term_pkg::COL_W-1:0];

    // byte being interpreted
    always_ff @(posedge i_clk) begin
        if ((state_q == ST_IDLE) && i_valid) begin
            char_q <= i_char;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q        <= ST_IDLE;
            row_q          <= '0;
            col_q          <= '0;
            scroll_start_q <= 1'b0;
            clear_start_q  <= 1'b0;
        end else begin
            scroll_start_q <= 1'b0;  // single-cycle start pulses
            clear_start_q  <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (i_valid) begin
                        state_q <= ST_NEW;
                    end
                end
                ST_NEW: begin
                    state_q <= ST_IDLE;
                    case (char_q)
                        term_pkg::C_NUL,
                        term_pkg::C_BEL: ;  // ignored
                        term_pkg::C_BS,
                        term_pkg::C_DEL: begin
                            if (col_q != '0) begin
                                col_q <= col_q - 1'b1;
                            end
                        end
                        term_pkg::C_HT: col_q <= tab_col;
                        term_pkg::C_CR: col_q <= '0;
                        term_pkg::C_LF: begin
                            if (row_q == ROW_LAST) begin
                                scroll_start_q <= 1'b1;  // bottom line, shift text up
                                state_q        <= ST_SCROLLING;
                            end else begin
                                row_q <= row_q + 1'b1;
                            end
                        end
                        term_pkg::C_FF: begin
                            row_q         <= '0;
                            col_q         <= '0;
                            clear_start_q <= 1'b1;
                            state_q       <= ST_CLEARING;
                        end
                        term_pkg::C_DC4: state_q <= ST_WAIT_ROW;
                        default: state_q <= ST_WRITING;  // printable
                    endcase
                end
                ST_WRITING: begin
                    state_q <= ST_IDLE;
                    if (col_q == COL_LAST) begin
                        col_q <= '0;  // auto margin
                        if (row_q == ROW_LAST) begin
                            scroll_start_q <= 1'b1;
                            state_q        <= ST_SCROLLING;
                        end else begin
                            row_q <= row_q + 1'b1;
                        end
                    end else begin
                        col_q <= col_q + 1'b1;
                    end
                end
                ST_SCROLLING: begin
                    if (!scroll_start_q && !scr_busy) begin
                        state_q <= ST_IDLE;
                    end
                end
                ST_CLEARING: begin
                    if (!clear_start_q && !clr_busy) begin
                        state_q <= ST_IDLE;
                    end
                end
                ST_WAIT_ROW: begin
                    if (i_valid) begin
                        row_q   <= (pos_val > LAST_ROW) ? ROW_LAST : pos_val[term_pkg::ROW_W-1:0];
                        state_q <= ST_WAIT_COL;
                    end
                end
                ST_WAIT_COL: begin
                    if (i_valid) begin
                        col_q   <= (pos_val > LAST_COL) ? COL_LAST : pos_val[term_pkg::COL_W-1:0];
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // the running engine owns the VRAM port
    always_comb begin
        case (state_q)
            ST_SCROLLING: begin
                o_vram_addr  = scr_addr;
                o_vram_wdata = scr_wdata;
                o_vram_we    = scr_we;
            end
            ST_CLEARING: begin
                o_vram_addr  = clr_addr;
                o_vram_wdata = clr_wdata;
                o_vram_we    = clr_we;
            end
            default: begin
                o_vram_addr  = {row_q, col_q};
                o_vram_wdata = char_q;
                o_vram_we    = (state_q == ST_WRITING);
            end
        endcase
    end

    scroll_engine #(
        .LAST_ROW (LAST_ROW),
        .LAST_COL (LAST_COL)
    ) u_scroll (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (scroll_start_q),
        .o_busy       (scr_busy),
        .o_vram_addr  (scr_addr),
        .o_vram_wdata (scr_wdata),
        .o_vram_we    (scr_we),
        .i_vram_rdata (i_vram_rdata)
    );

    clear_engine #(
        .LAST_ROW (LAST_ROW),
        .LAST_COL (LAST_COL)
    ) u_clear (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (clear_start_q),
        .o_busy       (clr_busy),
        .o_vram_addr  (clr_addr),
        .o_vram_wdata (clr_wdata),
        .o_vram_we    (clr_we)
    );

endmodule

/* src/text_term_top.sv */
// text terminal top level; joins the byte interpreter to the video RAM and sets the screen size
`timescale 1ns/1ps

module text_term_top #(
    parameter int unsigned LAST_ROW = 16,
    parameter int unsigned LAST_COL = 59
) (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic [term_pkg::CHAR_W-1:0] i_char,
    input  logic                        i_valid,
    output logic                        o_ready,
    output logic [term_pkg::ROW_W-1:0]  o_cursor_row,
    output logic [term_pkg::COL_W-1:0]  o_cursor_col,
    input  logic [term_pkg::ADDR_W-1:0] i_disp_addr,
    output logic [term_pkg::CHAR_W-1:0] o_disp_data
);

    logic [term_pkg::ADDR_W-1:0] vram_addr;
    logic [term_pkg::CHAR_W-1:0] vram_wdata;
    logic                        vram_we;
    logic [term_pkg::CHAR_W-1:0] vram_rdata;

    term_control #(
        .LAST_ROW (LAST_ROW),
        .LAST_COL (LAST_COL)
    ) u_control (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_char       (i_char),
        .i_valid      (i_valid),
        .o_ready      (o_ready),
        .o_cursor_row (o_cursor_row),
        .o_cursor_col (o_cursor_col),
        .o_vram_addr  (vram_addr),
        .o_vram_wdata (vram_wdata),
        .o_vram_we    (vram_we),
        .i_vram_rdata (vram_rdata)
    );

    text_vram u_vram (
        .i_clk       (i_clk),
        .i_addr      (vram_addr),
        .i_wdata     (vram_wdata),
        .i_we        (vram_we),
        .o_rdata     (vram_rdata),
        .i_disp_addr (i_disp_addr),
        .o_disp_data (o_disp_data)
    );

endmodule

/* sim/text_term_tb.sv */
// testbench for the text terminal; feeds byte streams and checks the screen against a shadow model
`timescale 1ns/1ps

module text_term_tb;

    localparam int LAST_ROW = 3;
    localparam int LAST_COL = 7;
    localparam int TIMEOUT  = 4000;  // about ten times the clear and scroll work in cycles

    logic                        i_clk;
    logic                        i_rst_n;
    logic [term_pkg::CHAR_W-1:0] i_char;
    logic                        i_valid;
    logic                        o_ready;
    logic [term_pkg::ROW_W-1:0]  o_cursor_row;
    logic [term_pkg::COL_W-1:0]  o_cursor_col;
    logic [term_pkg::ADDR_W-1:0] i_disp_addr;
    logic [term_pkg::CHAR_W-1:0] o_disp_data;

    logic [7:0] scr [0:LAST_ROW][0:LAST_COL];  // shadow screen
    int     cur_row;
    int     cur_col;
    int     dc4_phase;                         // 1 or 2 while DC4 arguments are due
    integer seed;
    int     errors;
    int     case_err;
    int     case_no;
    int     cases_ok;
    int     cases_bad;
    int     cycles;
    int     last_stalls;

    text_term_top #(
        .LAST_ROW (LAST_ROW),
        .LAST_COL (LAST_COL)
    ) dut (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_char       (i_char),
        .i_valid      (i_valid),
        .o_ready      (o_ready),
        .o_cursor_row (o_cursor_row),
        .o_cursor_col (o_cursor_col),
        .i_disp_addr  (i_disp_addr),
        .o_disp_data  (o_disp_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    always @(posedge i_clk) cycles <= cycles + 1;

    initial begin
        wait (cycles >= TIMEOUT);
        $display("run stalled in case %0d, no progress after %0d cycles", case_no, cycles);
        $display("test failed");
        $finish;
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("MISMATCH %s: expected 0x%0h, got 0x%0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic scroll_model();
        for (int r = 0; r < LAST_ROW; r++) begin
            for (int c = 0; c <= LAST_COL; c++) scr[r][c] = scr[r+1][c];
        end
        for (int c = 0; c <= LAST_COL; c++) scr[LAST_ROW][c] = term_pkg::BLANK;
    endtask

    // terminal rules applied to one accepted byte
    task automatic model_byte(input logic [7:0] c);
        logic [7:0] v;
        int         tab;
        v   = c - term_pkg::POS_OFFSET;
        tab = (cur_col / int'(term_pkg::TAB_STEP) + 1) * int'(term_pkg::TAB_STEP);
        if (dc4_phase == 1) begin
            cur_row   = (v > LAST_ROW) ? LAST_ROW : v;
            dc4_phase = 2;
        end else if (dc4_phase == 2) begin
            cur_col   = (v > LAST_COL) ? LAST_COL : v;
            dc4_phase = 0;
        end else begin
            case (c)
                term_pkg::C_NUL, term_pkg::C_BEL: ;
                term_pkg::C_BS, term_pkg::C_DEL: if (cur_col > 0) cur_col--;
                term_pkg::C_HT: cur_col = (tab > LAST_COL) ? LAST_COL : tab;
                term_pkg::C_CR: cur_col = 0;
                term_pkg::C_DC4: dc4_phase = 1;
                term_pkg::C_LF: begin
                    if (cur_row == LAST_ROW) scroll_model();
                    else cur_row++;
                end
                term_pkg::C_FF: begin
                    foreach (scr[r, k]) scr[r][k] = term_pkg::BLANK;
                    cur_row = 0;
                    cur_col = 0;
                end
                default: begin
                    scr[cur_row][cur_col] = c;
                    if (cur_col == LAST_COL) begin
                        cur_col = 0;  // auto margin
                        if (cur_row == LAST_ROW) scroll_model();
                        else cur_row++;
                    end else begin
                        cur_col++;
                    end
                end
            endcase
        end
    endtask

    // holds the byte until the DUT takes it; returns on the falling edge after acceptance
    task automatic send_byte(input logic [7:0] c);
        int stalls;
        bit is_arg;
        stalls = 0;
        is_arg = (dc4_phase != 0);
        @(negedge i_clk);
        i_char  = c;
        i_valid = 1'b1;
        while (!o_ready) begin
            @(negedge i_clk);
            stalls++;
        end
        @(negedge i_clk);
        i_valid     = 1'b0;
        last_stalls = stalls;
        if (!is_arg) begin
            assert (!o_ready) else begin
                $display("o_ready stayed high in the cycle after byte 0x%0h was taken", c);
                errors++;
            end
        end
        model_byte(c);
    endtask

    task automatic wait_idle();
        while (!o_ready) @(negedge i_clk);
    endtask

    task automatic check_cursor();
        check_val("o_cursor_row", cur_row, o_cursor_row);
        check_val("o_cursor_col", cur_col, o_cursor_col);
    endtask

    task automatic send_and_settle(input logic [7:0] c);
        send_byte(c);
        wait_idle();
        check_cursor();
    endtask

    task automatic check_screen();
        for (int r = 0; r <= LAST_ROW; r++) begin
            for (int c = 0; c <= LAST_COL; c++) begin
                @(negedge i_clk);
                i_disp_addr = (r << term_pkg::COL_W) | c;
                @(negedge i_clk);  // registered read port
                check_val($sformatf("o_disp_data[%0d][%0d]", r, c), scr[r][c], o_disp_data);
            end
        end
    endtask

    task automatic check_stalled(input string what);
        assert (last_stalls > 0) else begin
            $display("byte was taken while the %s was still running", what);
            errors++;
        end
    endtask

    task automatic start_case(input int n);
        case_no  = n;
        case_err = errors;
    endtask

    task automatic end_case(input string name);
        if (errors == case_err) begin
            cases_ok++;
            $display("case %0d %s: ok", case_no, name);
        end else begin
            cases_bad++;
            $display("case %0d %s: %0d errors", case_no, name, errors - case_err);
        end
    endtask

    function automatic logic [7:0] rand_printable();
        return 8'h21 + 8'($unsigned($random(seed)) % 94);
    endfunction

    initial begin
        i_rst_n     = 1'b0;
        i_char      = '0;
        i_valid     = 1'b0;
        i_disp_addr = '0;
        seed        = 98728;
        cur_row     = 0;
        cur_col     = 0;
        dc4_phase   = 0;
        errors      = 0;
        cases_ok    = 0;
        cases_bad   = 0;
        cycles      = 0;
        case_no     = 0;
        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;

        start_case(1);
        check_val("o_ready", 1, o_ready);
        check_cursor();
        send_and_settle(term_pkg::C_FF);
        check_screen();
        end_case("reset and clear");

        start_case(2);
        repeat (20) send_and_settle(rand_printable());  // wraps over two rows
        check_screen();
        end_case("printable bytes");

        start_case(3);
        send_and_settle(term_pkg::C_CR);
        send_and_settle(8'h61);
        send_and_settle(8'h62);
        send_and_settle(8'h63);
        send_and_settle(term_pkg::C_BS);
        send_and_settle(term_pkg::C_DEL);
        send_and_settle(term_pkg::C_BS);
        send_and_settle(term_pkg::C_BS);  // already at column 0
        send_and_settle(term_pkg::C_HT);
        send_and_settle(term_pkg::C_NUL);
        send_and_settle(term_pkg::C_BEL);
        send_and_settle(term_pkg::C_LF);  // not on the last row yet
        send_and_settle(term_pkg::C_CR);
        check_screen();
        end_case("cursor controls");

        start_case(4);
        send_and_settle(term_pkg::C_DC4);
        send_and_settle(8'h22);
        send_and_settle(8'h25);
        send_and_settle(term_pkg::C_DC4);
        send_and_settle(8'h10);  // wraps below the offset and clamps
        send_and_settle(8'h7F);
        end_case("dc4 positioning");

        start_case(5);
        send_and_settle(rand_printable());  // write to the last cell scrolls
        check_screen();
        send_and_settle(term_pkg::C_LF);
        check_screen();
        end_case("scrolling");

        start_case(6);
        send_byte(term_pkg::C_LF);
        send_byte(8'h5A);
        check_stalled("scroll");
        wait_idle();
        check_cursor();
        send_byte(term_pkg::C_FF);
        send_byte(8'h41);
        check_stalled("clear");
        wait_idle();
        check_cursor();
        check_screen();
        end_case("held bytes during scroll and clear");

        $display("cases ok: %0d, cases with errors: %0d", cases_ok, cases_bad);
        if (cases_bad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* src.f */
src/term_pkg.sv
src/text_vram.sv
src/clear_engine.sv
src/scroll_engine.sv
src/term_control.sv
src/text_term_top.sv
sim/text_term_tb.sv
